// File: project.f
logic/i2f_pkg.sv
logic/lzc.sv
logic/i2f_capture.sv
logic/i2f_normalize.sv
logic/i2f_round_pack.sv
logic/i2f_top.sv
test/i2f_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the converter testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f project.f --top-module i2f_tb; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vi2f_tb 2>&1)
status=$?
printf '%s\n' "$out"

if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST OK"; then
  exit 0
fi

echo "Pass message not found in simulation output"
exit 1

// File: test/i2f_tb.sv
// Integer to float converter testbench
module i2f_tb;

  // Upper bound on the operands the directed tests present
  localparam int DirectedOps = 128;
  localparam int RandomOps = 200;
  // Each test spends a few idle and drain cycles of its own
  localparam int TestCount = 5;
  localparam int TestOverhead = 12;
  // Random operands may each be followed by one idle gap
  localparam int PlannedCycles = 2 + TestCount * TestOverhead + DirectedOps + 2 * RandomOps;
  localparam int TimeoutUnits = (PlannedCycles + 50) * 20;
  // A result is due 3 cycles after its strobe, so this is plenty
  localparam int DrainLimit = 8;

  logic                             clk_i;
  logic                             reset_i;
  logic                             in_valid_i;
  i2f_pkg::i2f_op_e                 op_i;
  logic [i2f_pkg::OperandWidth-1:0] operand_i;
  logic                             out_valid_o;
  logic [i2f_pkg::OperandWidth-1:0] result_o;
  logic                             inexact_o;

  // Expected results in strobe order, with the cycle each one is due in
  int          exp_due[$];
  logic [32:0] exp_word[$];

  int    cycle = 0;
  int    seed = 32'hbc09;
  int    data_errors = 0;
  int    protocol_errors = 0;
  logic  checking = 1'b0;
  string test_name = "reset";

  i2f_top u_dut (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .in_valid_i  (in_valid_i),
    .op_i        (op_i),
    .operand_i   (operand_i),
    .out_valid_o (out_valid_o),
    .result_o    (result_o),
    .inexact_o   (inexact_o)
  );

  initial clk_i = 1'b0;
  always #10 clk_i = ~clk_i;

  // Cycle count advances on the rising edge and is read on the falling one
  always @(posedge clk_i) begin
    cycle <= cycle + 1;
  end

  // Reference conversion built from the IEEE-754 rules
  // Returns the inexact flag above the 32-bit result word
  function automatic logic [32:0] expected_of(input i2f_pkg::i2f_op_e op,
                                              input logic [31:0] value);
    logic        sign;
    logic [31:0] mag;
    logic [63:0] wide;
    logic [24:0] sig;
    logic        guard;
    logic        sticky;
    int          msb;
    int          exp;
    sign = (op == i2f_pkg::I2F_OP_SIGNED) && value[31];
    mag  = sign ? 32'd0 - value : value;
    if (mag == 32'd0) begin
      return 33'd0;
    end
    msb = 31;
    while (!mag[msb]) begin
      msb--;
    end
    // Put the leading one at bit 63 so the 24-bit significand is bits 63..40
    wide   = {32'd0, mag} << (63 - msb);
    sig    = {1'b0, wide[63:40]};
    guard  = wide[39];
    sticky = |wide[38:0];
    exp    = int'(i2f_pkg::ExpBias) + msb;
    if (guard && (sticky || sig[0])) begin
      sig = sig + 25'd1;
    end
    // A carry leaves 1 followed by zeros, so only the exponent moves
    if (sig[24]) begin
      exp = exp + 1;
    end
    return {guard | sticky, sign, 8'(exp), sig[22:0]};
  endfunction

  // Present one operand on the next falling edge and queue its result
  task automatic send(input i2f_pkg::i2f_op_e op, input logic [31:0] value);
    @(negedge clk_i);
    in_valid_i = 1'b1;
    op_i       = op;
    operand_i  = value;
    exp_due.push_back(cycle + 3);
    exp_word.push_back(expected_of(op, value));
  endtask

  task automatic idle();
    @(negedge clk_i);
    in_valid_i = 1'b0;
  endtask

  // Stop strobing and wait until every queued result has come out
  task automatic drain();
    int waited;
    waited = 0;
    idle();
    while (exp_due.size() > 0 && waited < DrainLimit) begin
      @(negedge clk_i);
      waited++;
    end
  endtask

  // Outputs are registered on the rising edge and compared on the falling one
  always @(negedge clk_i) begin : monitor
    logic due_now;
    due_now = (exp_due.size() > 0) && (exp_due[0] == cycle);
    if (checking && due_now) begin
      assert (out_valid_o === 1'b1) else begin
        protocol_errors++;
        $display("%s: no out_valid_o 3 cycles after the strobe of cycle %0d",
                 test_name, cycle - 3);
      end
      if (out_valid_o === 1'b1) begin
        assert ({inexact_o, result_o} === exp_word[0]) else begin
          data_errors++;
          $display("ERROR %s: expected result %h inexact %b, actual result %h inexact %b",
                   test_name, exp_word[0][31:0], exp_word[0][32], result_o, inexact_o);
        end
      end
      void'(exp_due.pop_front());
      void'(exp_word.pop_front());
    end else if (checking) begin
      assert (out_valid_o === 1'b0) else begin
        protocol_errors++;
        $display("%s: out_valid_o high at cycle %0d with no conversion due",
                 test_name, cycle);
      end
    end
  end

  // Idle output after reset, then one strobe must give a single pulse
  task automatic reset_and_latency();
    int waited;
    test_name = "reset_and_latency";
    repeat (4) idle();
    send(i2f_pkg::I2F_OP_UNSIGNED, 32'd5);
    waited = 0;
    while (out_valid_o !== 1'b1 && waited < DrainLimit) begin
      idle();
      waited++;
    end
    assert (waited == 3) else begin
      protocol_errors++;
      $display("%s: out_valid_o came %0d cycles after the strobe instead of 3",
               test_name, waited);
    end
    idle();
    assert (out_valid_o === 1'b0) else begin
      protocol_errors++;
      $display("%s: out_valid_o stayed high for more than one cycle", test_name);
    end
    drain();
  endtask

  // Zero, every power of two and small negatives walk the counter through all counts
  task automatic exact_values();
    test_name = "exact_values";
    send(i2f_pkg::I2F_OP_SIGNED, 32'd0);
    send(i2f_pkg::I2F_OP_UNSIGNED, 32'd0);
    for (int k = 0; k < 32; k++) begin
      send(i2f_pkg::I2F_OP_UNSIGNED, 32'd1 << k);
    end
    for (int k = 0; k < 31; k++) begin
      send(i2f_pkg::I2F_OP_SIGNED, 32'd1 << k);
    end
    for (int k = 1; k <= 8; k++) begin
      send(i2f_pkg::I2F_OP_SIGNED, 32'd0 - 32'(k));
    end
    send(i2f_pkg::I2F_OP_SIGNED, 32'h8000_0000);
    drain();
  endtask

  // Guard and sticky below half, ties both ways, above half and a carry
  task automatic rounding_cases();
    logic [31:0] values [8] = '{32'h0100_0001, 32'h0100_0003, 32'h0200_0001,
                                32'h0200_0002, 32'h0200_0003, 32'h0200_0006,
                                32'h00ff_ffff, 32'hffff_ffff};
    test_name = "rounding_cases";
    foreach (values[i]) begin
      send(i2f_pkg::I2F_OP_UNSIGNED, values[i]);
    end
    send(i2f_pkg::I2F_OP_SIGNED, 32'h7fff_ffff);
    send(i2f_pkg::I2F_OP_SIGNED, 32'hfeff_ffff);
    drain();
  endtask

  // Top bit set means negative under one opcode and large under the other
  task automatic opcode_select();
    logic [31:0] values [5] = '{32'h8000_0000, 32'hffff_ffff, 32'hc000_0001,
                                32'h8000_0001, 32'hffff_fff0};
    test_name = "opcode_select";
    foreach (values[i]) begin
      send(i2f_pkg::I2F_OP_SIGNED, values[i]);
      send(i2f_pkg::I2F_OP_UNSIGNED, values[i]);
    end
    drain();
  endtask

  task automatic back_to_back();
    logic [31:0] pick;
    logic [31:0] value;
    test_name = "back_to_back";
    for (int i = 0; i < RandomOps; i++) begin
      pick  = $random(seed);
      value = $random(seed);
      // Narrow some operands so small magnitudes show up too
      if (pick[1]) begin
        value = value >> pick[8:4];
      end
      send(i2f_pkg::i2f_op_e'(pick[0]), value);
      // About one strobe in eight is followed by a gap
      if (pick[15:13] == 3'd0) begin
        idle();
      end
    end
    drain();
  endtask

  initial begin
    reset_i    = 1'b1;
    in_valid_i = 1'b0;
    op_i       = i2f_pkg::I2F_OP_SIGNED;
    operand_i  = '0;
    repeat (2) @(negedge clk_i);
    reset_i  = 1'b0;
    checking = 1'b1;
    reset_and_latency();
    exact_values();
    rounding_cases();
    opcode_select();
    back_to_back();
    $display("Checks done with %0d value errors and %0d protocol errors",
             data_errors, protocol_errors);
    if (data_errors == 0 && protocol_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Watchdog sized from the expected number of cycles
  initial begin
    #(TimeoutUnits);
    $display("Timeout in %s after %0d cycles, the run did not finish", test_name, cycle);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// File: logic/i2f_top.sv
// Integer to float converter
module i2f_top (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic                                in_valid_i,
  input  i2f_pkg::i2f_op_e                    op_i,
  input  logic [i2f_pkg::OperandWidth-1:0]    operand_i,
  output logic                                out_valid_o,
  output logic [i2f_pkg::OperandWidth-1:0]    result_o,
  output logic                                inexact_o
);

  // Capture to normalize
  logic                             s1_valid;
  logic                             s1_sign;
  logic [i2f_pkg::OperandWidth-1:0] s1_mag;

  // Normalize to round and pack
  logic                             s2_valid;
  logic                             s2_sign;
  logic                             s2_zero;
  logic [i2f_pkg::ExpWidth-1:0]     s2_exp;
  logic [i2f_pkg::OperandWidth-1:0] s2_mant;

  // First stage forms sign and magnitude
  i2f_capture u_capture (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .in_valid_i (in_valid_i),
    .op_i       (op_i),
    .operand_i  (operand_i),
    .s1_valid_o (s1_valid),
    .s1_sign_o  (s1_sign),
    .s1_mag_o   (s1_mag)
  );

  // Second stage lines the leading one up with the MSB
  i2f_normalize u_normalize (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .s1_valid_i (s1_valid),
    .s1_sign_i  (s1_sign),
    .s1_mag_i   (s1_mag),
    .s2_valid_o (s2_valid),
    .s2_sign_o  (s2_sign),
    .s2_zero_o  (s2_zero),
    .s2_exp_o   (s2_exp),
    .s2_mant_o  (s2_mant)
  );

  // Third stage rounds and drives the outputs
  i2f_round_pack u_round_pack (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .s2_valid_i  (s2_valid),
    .s2_sign_i   (s2_sign),
    .s2_zero_i   (s2_zero),
    .s2_exp_i    (s2_exp),
    .s2_mant_i   (s2_mant),
    .out_valid_o (out_valid_o),
    .result_o    (result_o),
    .inexact_o   (inexact_o)
  );

endmodule

// File: logic/i2f_round_pack.sv
// Conversion round and pack stage
module i2f_round_pack (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic                                s2_valid_i,
  input  logic                                s2_sign_i,
  input  logic                                s2_zero_i,
  input  logic [i2f_pkg::ExpWidth-1:0]        s2_exp_i,
  input  logic [i2f_pkg::OperandWidth-1:0]    s2_mant_i,
  output logic                                out_valid_o,
  output logic [i2f_pkg::OperandWidth-1:0]    result_o,
  output logic                                inexact_o
);

  // Position of the guard bit, just below the 24-bit significand
  localparam int unsigned GuardPos = i2f_pkg::OperandWidth - i2f_pkg::FracWidth - 2;

  logic [i2f_pkg::FracWidth:0]      significand;
  logic                             guard;
  logic                             sticky;
  logic                             round_up;
  logic [i2f_pkg::FracWidth+1:0]    rounded;
  logic                             carry;
  logic [i2f_pkg::ExpWidth-1:0]     final_exp;
  logic [i2f_pkg::FracWidth-1:0]    final_frac;
  logic [i2f_pkg::OperandWidth-1:0] packed_word;

  // Top 24 bits carry the hidden one and the fraction
  assign significand = s2_mant_i[i2f_pkg::OperandWidth-1 -: i2f_pkg::FracWidth+1];
  assign guard       = s2_mant_i[GuardPos];
  // Everything below the guard bit folds into sticky
  assign sticky      = |s2_mant_i[GuardPos-1:0];

  // Round to nearest, ties go to the even significand
  assign round_up = guard & (sticky | significand[0]);

  // One extra bit catches the carry out of an all-ones significand
  assign rounded = {1'b0, significand} + (i2f_pkg::FracWidth + 2)'(round_up);
  assign carry   = rounded[i2f_pkg::FracWidth+1];

  // On carry the value becomes the next power of two
  // so the exponent steps up and the fraction clears
  assign final_exp  = s2_exp_i + i2f_pkg::ExpWidth'(carry);
  assign final_frac = carry ? '0 : rounded[i2f_pkg::FracWidth-1:0];

  // A zero input packs to +0, the counter's exponent is meaningless there
  assign packed_word = s2_zero_i ? '0 : {s2_sign_i, final_exp, final_frac};

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      out_valid_o <= 1'b0;
    end else begin
      out_valid_o <= s2_valid_i;
    end
  end

  // Result and flag are held until the next strobe replaces them
  always_ff @(posedge clk_i) begin
    if (s2_valid_i) begin
      result_o  <= packed_word;
      // Any bit dropped below the significand makes the result inexact
      inexact_o <= ~s2_zero_i & (guard | sticky);
    end
  end

endmodule

// File: logic/i2f_normalize.sv
// Conversion normalize stage
module i2f_normalize (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic                                s1_valid_i,
  input  logic                                s1_sign_i,
  input  logic [i2f_pkg::OperandWidth-1:0]    s1_mag_i,
  output logic                                s2_valid_o,
  output logic                                s2_sign_o,
  output logic                                s2_zero_o,
  output logic [i2f_pkg::ExpWidth-1:0]        s2_exp_o,
  output logic [i2f_pkg::OperandWidth-1:0]    s2_mant_o
);

  // Exponent for a magnitude whose MSB is already in the top position
  localparam logic [i2f_pkg::ExpWidth-1:0] ExpTop =
      i2f_pkg::ExpWidth'(i2f_pkg::ExpBias + i2f_pkg::OperandWidth - 1);

  logic [i2f_pkg::CntWidth-1:0]     lz_cnt;
  logic                             lz_empty;
  logic [i2f_pkg::OperandWidth-1:0] shifted;
  logic [i2f_pkg::ExpWidth-1:0]     biased_exp;

  // Count from the MSB to find how far the magnitude sits from the top
  lzc #(
    .WIDTH (i2f_pkg::OperandWidth),
    .MODE  (1'b1)
  ) u_lzc (
    .in_i    (s1_mag_i),
    .cnt_o   (lz_cnt),
    .empty_o (lz_empty)
  );

  // Shift the leading one up to the MSB
  // A zero magnitude stays zero whatever the count is
  assign shifted = s1_mag_i << lz_cnt;

  // Every position the leading one moves up lowers the exponent by one
  assign biased_exp = ExpTop - i2f_pkg::ExpWidth'(lz_cnt);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      s2_valid_o <= 1'b0;
    end else begin
      s2_valid_o <= s1_valid_i;
    end
  end

  // Payload moves forward with the strobe
  always_ff @(posedge clk_i) begin
    if (s1_valid_i) begin
      s2_sign_o <= s1_sign_i;
      s2_zero_o <= lz_empty;
      s2_exp_o  <= biased_exp;
      s2_mant_o <= shifted;
    end
  end

endmodule

// File: logic/i2f_capture.sv
// Conversion input stage
module i2f_capture (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic                                in_valid_i,
  input  i2f_pkg::i2f_op_e                    op_i,
  input  logic [i2f_pkg::OperandWidth-1:0]    operand_i,
  output logic                                s1_valid_o,
  output logic                                s1_sign_o,
  output logic [i2f_pkg::OperandWidth-1:0]    s1_mag_o
);

  logic                             is_signed;
  logic                             negative;
  logic [i2f_pkg::OperandWidth-1:0] magnitude;

  // Only a signed conversion gives meaning to the top bit
  assign is_signed = (op_i == i2f_pkg::I2F_OP_SIGNED);
  assign negative  = is_signed & operand_i[i2f_pkg::OperandWidth-1];

  // Two's complement negation, the most negative value maps onto 2^31
  // which is still representable as an unsigned magnitude
  assign magnitude = negative ? (~operand_i + 1'b1) : operand_i;

  // The strobe register is the only control state here
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      s1_valid_o <= 1'b0;
    end else begin
      s1_valid_o <= in_valid_i;
    end
  end

  // Sign and magnitude are only loaded alongside a strobe
  always_ff @(posedge clk_i) begin
    if (in_valid_i) begin
      s1_sign_o <= negative;
      s1_mag_o  <= magnitude;
    end
  end

endmodule

// File: logic/lzc.sv
// Leading and trailing zero counter
module lzc #(
  // Number of bits in the vector being counted
  parameter int unsigned WIDTH = 2,
  // Set to 1 to count from the MSB, to 0 to count from the LSB
  parameter bit          MODE  = 1'b0,
  // Count width follows from WIDTH and is not meant to be overridden
  localparam int unsigned CNT_WIDTH = (WIDTH > 1) ? $clog2(WIDTH) : 1
) (
  input  logic [WIDTH-1:0]     in_i,
  output logic [CNT_WIDTH-1:0] cnt_o,
  output logic                 empty_o
);

  if (WIDTH == 1) begin : gen_single

    // A single bit has only one index, so the count is always zero
    assign cnt_o   = '0;
    assign empty_o = ~in_i[0];

  end else begin : gen_tree

    // The tree is padded up to the next power of two
    localparam int unsigned Leaves = 2 ** CNT_WIDTH;

    logic [WIDTH-1:0]     ordered;
    logic [2*Leaves-2:0]  node_hit;
    logic [CNT_WIDTH-1:0] node_idx [2*Leaves-1];

    // In leading mode the vector is mirrored so that index 0 is the MSB
    always_comb begin : mirror
      for (int unsigned i = 0; i < WIDTH; i++) begin
        ordered[i] = MODE ? in_i[WIDTH-1-i] : in_i[i];
      end
    end

    // Heap layout with the root at node 0 and the leaves at Leaves-1 upward
    // Each inner node is the OR of its children and keeps the index of the
    // lower child that has a set bit
    always_comb begin : build_tree
      for (int unsigned i = 0; i < Leaves; i++) begin
        if (i < WIDTH) begin
          node_hit[Leaves-1+i] = ordered[i];
          node_idx[Leaves-1+i] = CNT_WIDTH'(i);
        end else begin
          // Padding leaves never hit and point at the last real index
          node_hit[Leaves-1+i] = 1'b0;
          node_idx[Leaves-1+i] = CNT_WIDTH'(WIDTH - 1);
        end
      end
      for (int n = int'(Leaves) - 2; n >= 0; n--) begin
        node_hit[n] = node_hit[2*n+1] | node_hit[2*n+2];
        node_idx[n] = node_hit[2*n+1] ? node_idx[2*n+1] : node_idx[2*n+2];
      end
    end

    // With no bit set the root falls through to the right edge
    // so an empty vector reports the maximum index
    assign cnt_o   = node_idx[0];
    assign empty_o = ~node_hit[0];

  end

endmodule

// File: logic/i2f_pkg.sv
// Integer to float shared definitions
package i2f_pkg;

  // Width of the integer operand and of the packed result word
  localparam int unsigned OperandWidth = 32;

  // Number of bits needed to hold a zero count over one operand
  localparam int unsigned CntWidth = $clog2(OperandWidth);

  // Exponent field of a single-precision word
  localparam int unsigned ExpWidth = 8;

  // Fraction field of a single-precision word, hidden bit not included
  localparam int unsigned FracWidth = 23;

  // Bias added to the true exponent before it is packed
  localparam int unsigned ExpBias = 127;

  // Conversion opcode presented with each operand
  // The signed form reads the top bit as a sign, the unsigned form does not
  typedef enum logic [0:0] {
    I2F_OP_SIGNED   = 1'b0,
    I2F_OP_UNSIGNED = 1'b1
  } i2f_op_e;

endpackage
